/* hdl/mem_cfg_pkg.sv */
// memory dispatch configuration
// group width, data width, queue depths and index types
`default_nettype none

package mem_cfg_pkg;

    // dispatch group and datapath
    localparam int DISP_WIDTH = 4;
    localparam int XLEN       = 32;
    localparam int ROB_W      = 6;

    // default queue depths
    localparam int LQ_SIZE = 16;
    localparam int SQ_SIZE = 16;

    // load lanes and per-cycle acceptance limits
    localparam int LD_LANES       = 2;
    localparam int MAX_LD_PER_CYC = 2;
    localparam int MAX_ST_PER_CYC = 2;

    typedef logic [ROB_W-1:0] rob_idx_t;

    // indices sized from the default depths
    typedef logic [$clog2(LQ_SIZE)-1:0] lq_idx_t;
    typedef logic [$clog2(SQ_SIZE)-1:0] sq_idx_t;

endpackage

`default_nettype wire

/* hdl/mem_op_pkg.sv */
// memory micro-op definitions
// opcodes, access-size helpers, micro-op and load writeback records
`default_nettype none

package mem_op_pkg;
    import mem_cfg_pkg::*;

    // bit 2 set for stores
    typedef enum logic [2:0] {
        LB = 3'd0,
        LH = 3'd1,
        LW = 3'd2,
        SB = 3'd4,
        SH = 3'd5,
        SW = 3'd6
    } mem_op_e;

    function automatic logic is_load(mem_op_e op);
        return (op == LB) || (op == LH) || (op == LW);
    endfunction

    // access size in bytes
    function automatic logic [2:0] access_bytes(mem_op_e op);
        case (op)
            LB, SB:  return 3'd1;
            LH, SH:  return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    typedef struct packed {
        mem_op_e         op;
        rob_idx_t        rob;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] imm;
        lq_idx_t         lq_idx;
        sq_idx_t         sq_idx;
    } mem_uop_t;

    typedef struct packed {
        rob_idx_t        rob;
        lq_idx_t         lq_idx;
        logic [XLEN-1:0] addr;
        logic            misalign;
    } ld_wb_t;

endpackage

`default_nettype wire

/* hdl/mem_disp_if.sv */
// dispatch group bundle and load issue bundle
// group request, accept mask and allocated queue indices; per-lane issue
`timescale 1ns/1ns
`default_nettype none

interface mem_disp_if import mem_cfg_pkg::*, mem_op_pkg::*; ();
    logic [DISP_WIDTH-1:0] req;
    mem_uop_t              uop [DISP_WIDTH];
    logic [DISP_WIDTH-1:0] rdy;
    lq_idx_t               lq_idx [DISP_WIDTH];
    sq_idx_t               sq_idx [DISP_WIDTH];

    modport ctrl  (input req, input uop, output rdy);
    modport alloc (input req, input uop, input rdy, output lq_idx, output sq_idx);
    modport sink  (input req, input uop, input rdy, input lq_idx, input sq_idx);
endinterface

// buffer head to address-generation lanes
interface ld_issue_if import mem_cfg_pkg::*, mem_op_pkg::*; ();
    logic [LD_LANES-1:0] vld;
    logic [LD_LANES-1:0] stall;
    mem_uop_t            uop [LD_LANES];

    modport src  (output vld, output uop, input stall);
    modport sink (input vld, input uop, input stall);
endinterface

`default_nettype wire

/* hdl/mem_dispatch_ctrl.sv */
// dispatch acceptance control
// cuts the group at the first slot that breaks a limit or finds no room
`timescale 1ns/1ns
`default_nettype none

module mem_dispatch_ctrl import mem_cfg_pkg::*, mem_op_pkg::*; #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_lsq_room,
    input  logic [$clog2(BUF_DEPTH+1)-1:0]  i_buf_space,
    output logic [$clog2(DISP_WIDTH+1)-1:0] o_acc_cnt,
    mem_disp_if.ctrl                        disp
);
    localparam int CNT_W = $clog2(DISP_WIDTH + 1);

    logic [DISP_WIDTH-1:0] slot_ld;
    logic [CNT_W-1:0]      acc_num;
    logic [CNT_W-1:0]      acc_cnt_q;

    always_comb begin
        for (int i = 0; i < DISP_WIDTH; i++) begin
            slot_ld[i] = is_load(disp.uop[i].op);
        end
    end

    // walk the slots in program order, once cut nothing later goes
    always_comb begin
        int unsigned n_ld;
        int unsigned n_st;
        logic        cut;
        n_ld = 0;
        n_st = 0;
        cut  = !i_lsq_room;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            disp.rdy[i] = 1'b0;
            if (!cut && disp.req[i] && slot_ld[i] &&
                (n_ld < MAX_LD_PER_CYC) && (n_ld < i_buf_space)) begin
                disp.rdy[i] = 1'b1;
                n_ld++;
            end else if (!cut && disp.req[i] && !slot_ld[i] &&
                         (n_st < MAX_ST_PER_CYC)) begin
                disp.rdy[i] = 1'b1;
                n_st++;
            end else begin
                cut = 1'b1;
            end
        end
        acc_num = CNT_W'(n_ld + n_st);
    end

    // ops accepted in the previous cycle
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            acc_cnt_q <= '0;
        end else begin
            acc_cnt_q <= acc_num;
        end
    end

    assign o_acc_cnt = acc_cnt_q;

endmodule

`default_nettype wire

/* hdl/lsq_alloc.sv */
// load/store queue allocator
// hands out consecutive queue indices and tracks free entries
`timescale 1ns/1ns
`default_nettype none

module lsq_alloc import mem_cfg_pkg::*, mem_op_pkg::*; #(
    parameter int LQ_DEPTH = LQ_SIZE,
    parameter int SQ_DEPTH = SQ_SIZE
) (
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic [1:0] i_ld_commit_num,
    input  logic [1:0] i_st_commit_num,
    output logic       o_lsq_room,
    mem_disp_if.alloc  disp
);
    localparam int LQ_CW  = $clog2(LQ_DEPTH + 1);
    localparam int SQ_CW  = $clog2(SQ_DEPTH + 1);
    localparam int ACC_W  = $clog2(DISP_WIDTH + 1);

    lq_idx_t          lq_tail_q;
    sq_idx_t          sq_tail_q;
    logic [LQ_CW-1:0] lq_free_q;
    logic [SQ_CW-1:0] sq_free_q;
    logic [ACC_W-1:0] ld_acc;
    logic [ACC_W-1:0] st_acc;

    // depth is at least the group width, one subtract is enough
    function automatic int unsigned wrap_add(int unsigned base, int unsigned n,
                                             int unsigned depth);
        int unsigned sum;
        sum = base + n;
        return (sum >= depth) ? sum - depth : sum;
    endfunction

    // index of each slot counts the accepted ops ahead of it
    always_comb begin
        int unsigned n_ld;
        int unsigned n_st;
        n_ld = 0;
        n_st = 0;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            disp.lq_idx[i] = lq_idx_t'(wrap_add(lq_tail_q, n_ld, LQ_DEPTH));
            disp.sq_idx[i] = sq_idx_t'(wrap_add(sq_tail_q, n_st, SQ_DEPTH));
            if (disp.req[i] && disp.rdy[i]) begin
                if (is_load(disp.uop[i].op)) begin
                    n_ld++;
                end else begin
                    n_st++;
                end
            end
        end
        ld_acc = ACC_W'(n_ld);
        st_acc = ACC_W'(n_st);
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            lq_tail_q <= '0;
            sq_tail_q <= '0;
            lq_free_q <= LQ_CW'(LQ_DEPTH);
            sq_free_q <= SQ_CW'(SQ_DEPTH);
        end else begin
            lq_tail_q <= lq_idx_t'(wrap_add(lq_tail_q, ld_acc, LQ_DEPTH));
            sq_tail_q <= sq_idx_t'(wrap_add(sq_tail_q, st_acc, SQ_DEPTH));
            lq_free_q <= lq_free_q - LQ_CW'(ld_acc) + LQ_CW'(i_ld_commit_num);
            sq_free_q <= sq_free_q - SQ_CW'(st_acc) + SQ_CW'(i_st_commit_num);
        end
    end

    // room for a full group in both queues
    assign o_lsq_room = (lq_free_q >= LQ_CW'(DISP_WIDTH)) &&
                        (sq_free_q >= SQ_CW'(DISP_WIDTH));

endmodule

`default_nettype wire

/* hdl/load_issue_buffer.sv */
// in-order load issue buffer
// takes accepted loads in slot order, offers the two oldest to the lanes
`timescale 1ns/1ns
`default_nettype none

module load_issue_buffer import mem_cfg_pkg::*, mem_op_pkg::*; #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_squash,
    output logic [$clog2(BUF_DEPTH+1)-1:0] o_space,
    mem_disp_if.sink                       disp,
    ld_issue_if.src                        iss
);
    // depth is a power of two so the pointers wrap on their own
    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    mem_uop_t                  mem_q [BUF_DEPTH];
    logic [PTR_W-1:0]          head_q;
    logic [PTR_W-1:0]          tail_q;
    logic [CNT_W-1:0]          count_q;
    logic [MAX_LD_PER_CYC-1:0] wr_vld;
    mem_uop_t                  wr_uop [MAX_LD_PER_CYC];
    logic [LD_LANES-1:0]       fire;
    logic [CNT_W-1:0]          n_wr;
    logic [CNT_W-1:0]          n_pop;

    // accepted loads packed to the front, queue indices filled in
    always_comb begin
        int unsigned k;
        k      = 0;
        wr_vld = '0;
        for (int w = 0; w < MAX_LD_PER_CYC; w++) begin
            wr_uop[w] = disp.uop[0];
        end
        for (int i = 0; i < DISP_WIDTH; i++) begin
            if (disp.req[i] && disp.rdy[i] && is_load(disp.uop[i].op) &&
                (k < MAX_LD_PER_CYC)) begin
                wr_vld[k]        = 1'b1;
                wr_uop[k]        = disp.uop[i];
                wr_uop[k].lq_idx = disp.lq_idx[i];
                wr_uop[k].sq_idx = disp.sq_idx[i];
                k++;
            end
        end
    end

    // a stalled lane blocks every younger lane
    always_comb begin
        logic blocked;
        blocked = 1'b0;
        for (int l = 0; l < LD_LANES; l++) begin
            iss.vld[l] = (count_q > CNT_W'(l)) && !blocked;
            iss.uop[l] = mem_q[head_q + PTR_W'(l)];
            fire[l]    = iss.vld[l] && !iss.stall[l];
            blocked    = blocked || iss.stall[l];
        end
    end

    assign n_wr  = CNT_W'($countones(wr_vld));
    assign n_pop = CNT_W'($countones(fire));

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_squash) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + PTR_W'(n_pop);
            tail_q  <= tail_q + PTR_W'(n_wr);
            count_q <= count_q + n_wr - n_pop;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < MAX_LD_PER_CYC; w++) begin
            if (wr_vld[w]) begin
                mem_q[tail_q + PTR_W'(w)] <= wr_uop[w];
            end
        end
    end

    assign o_space = CNT_W'(BUF_DEPTH) - count_q;

endmodule

`default_nettype wire

/* hdl/load_pipe.sv */
// load address-generation lanes
// effective address, alignment check, registered writeback and exception
`timescale 1ns/1ns
`default_nettype none

module load_pipe import mem_cfg_pkg::*, mem_op_pkg::*; (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_squash,
    ld_issue_if.sink            iss,
    output logic [LD_LANES-1:0] o_ld_wb_vld,
    output ld_wb_t              o_ld_wb [LD_LANES],
    output logic                o_except_vld,
    output ld_wb_t              o_except_info
);
    logic [LD_LANES-1:0] fire;
    logic [LD_LANES-1:0] fault;
    ld_wb_t              lane_wb [LD_LANES];
    ld_wb_t              oldest;

    always_comb begin
        logic [XLEN-1:0] ea;
        logic [2:0]      size;
        for (int l = 0; l < LD_LANES; l++) begin
            ea   = iss.uop[l].base + iss.uop[l].imm;
            size = access_bytes(iss.uop[l].op);
            lane_wb[l].rob      = iss.uop[l].rob;
            lane_wb[l].lq_idx   = iss.uop[l].lq_idx;
            lane_wb[l].addr     = ea;
            // low address bits must be clear below the access size
            lane_wb[l].misalign = (ea[2:0] & (size - 3'd1)) != 3'd0;
            fire[l]  = iss.vld[l] && !iss.stall[l];
            fault[l] = fire[l] && lane_wb[l].misalign;
        end
    end

    // smaller rob tag is the older load
    always_comb begin
        logic found;
        found  = 1'b0;
        oldest = lane_wb[0];
        for (int l = 0; l < LD_LANES; l++) begin
            if (fault[l] && (!found || (lane_wb[l].rob < oldest.rob))) begin
                oldest = lane_wb[l];
                found  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_squash) begin
            o_ld_wb_vld  <= '0;
            o_except_vld <= 1'b0;
        end else begin
            o_ld_wb_vld  <= fire;
            o_except_vld <= |fault;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LD_LANES; l++) begin
            if (fire[l]) begin
                o_ld_wb[l] <= lane_wb[l];
            end
        end
        if (|fault) begin
            o_except_info <= oldest;
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_block.sv */
// memory dispatch block top level
// acceptance, queue allocation, load issue buffer and two load lanes
`timescale 1ns/1ns
`default_nettype none

module mem_block import mem_cfg_pkg::*, mem_op_pkg::*; #(
    parameter int LQ_DEPTH  = LQ_SIZE,
    parameter int SQ_DEPTH  = SQ_SIZE,
    parameter int BUF_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_squash,
    input  logic [DISP_WIDTH-1:0]           i_disp_req,
    input  mem_op_e                         i_disp_op   [DISP_WIDTH],
    input  rob_idx_t                        i_disp_rob  [DISP_WIDTH],
    input  logic [XLEN-1:0]                 i_disp_base [DISP_WIDTH],
    input  logic [XLEN-1:0]                 i_disp_imm  [DISP_WIDTH],
    output logic [DISP_WIDTH-1:0]           o_disp_rdy,
    output logic [$clog2(DISP_WIDTH+1)-1:0] o_disp_cnt,
    input  logic [LD_LANES-1:0]             i_wb_stall,
    input  logic [1:0]                      i_ld_commit_num,
    input  logic [1:0]                      i_st_commit_num,
    output logic [LD_LANES-1:0]             o_ld_wb_vld,
    output ld_wb_t                          o_ld_wb [LD_LANES],
    output logic [DISP_WIDTH-1:0]           o_st_alloc_vld,
    output sq_idx_t                         o_st_alloc_sq  [DISP_WIDTH],
    output rob_idx_t                        o_st_alloc_rob [DISP_WIDTH],
    output logic                            o_except_vld,
    output ld_wb_t                          o_except_info
);
    localparam int SPACE_W = $clog2(BUF_DEPTH + 1);

    mem_disp_if disp ();
    ld_issue_if iss ();

    logic                  lsq_room;
    logic [SPACE_W-1:0]    buf_space;
    logic [DISP_WIDTH-1:0] st_acc;

    // queue indices are filled in by the allocator
    always_comb begin
        disp.req = i_disp_req;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            disp.uop[i] = '{op: i_disp_op[i], rob: i_disp_rob[i], base: i_disp_base[i],
                            imm: i_disp_imm[i], lq_idx: '0, sq_idx: '0};
        end
    end

    assign o_disp_rdy = disp.rdy;
    assign iss.stall  = i_wb_stall;

    mem_dispatch_ctrl #(.BUF_DEPTH(BUF_DEPTH)) u_ctrl (
        .clk(clk), .i_rst_n(i_rst_n), .i_lsq_room(lsq_room),
        .i_buf_space(buf_space), .o_acc_cnt(o_disp_cnt), .disp(disp.ctrl)
    );

    lsq_alloc #(.LQ_DEPTH(LQ_DEPTH), .SQ_DEPTH(SQ_DEPTH)) u_alloc (
        .clk(clk), .i_rst_n(i_rst_n), .i_ld_commit_num(i_ld_commit_num),
        .i_st_commit_num(i_st_commit_num), .o_lsq_room(lsq_room), .disp(disp.alloc)
    );

    load_issue_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buf (
        .clk(clk), .i_rst_n(i_rst_n), .i_squash(i_squash),
        .o_space(buf_space), .disp(disp.sink), .iss(iss.src)
    );

    load_pipe u_pipe (
        .clk(clk), .i_rst_n(i_rst_n), .i_squash(i_squash), .iss(iss.sink),
        .o_ld_wb_vld(o_ld_wb_vld), .o_ld_wb(o_ld_wb),
        .o_except_vld(o_except_vld), .o_except_info(o_except_info)
    );

    // store allocation reported the cycle after acceptance, per slot
    always_comb begin
        for (int i = 0; i < DISP_WIDTH; i++) begin
            st_acc[i] = disp.req[i] && disp.rdy[i] && !is_load(i_disp_op[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_st_alloc_vld <= '0;
        end else begin
            o_st_alloc_vld <= st_acc;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DISP_WIDTH; i++) begin
            if (st_acc[i]) begin
                o_st_alloc_sq[i]  <= disp.sq_idx[i];
                o_st_alloc_rob[i] <= i_disp_rob[i];
            end
        end
    end

endmodule

`default_nettype wire

/* sim/mem_block_checker.sv */
// memory dispatch block checker
// predicts accept, store allocation, load writeback and exception
`timescale 1ns/1ns
`default_nettype none

module mem_block_checker import mem_cfg_pkg::*, mem_op_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_squash,
    input  logic                  i_done,
    input  int                    i_tid,
    input  logic [DISP_WIDTH-1:0] i_disp_req,
    input  mem_op_e               i_disp_op   [DISP_WIDTH],
    input  rob_idx_t              i_disp_rob  [DISP_WIDTH],
    input  logic [XLEN-1:0]       i_disp_base [DISP_WIDTH],
    input  logic [XLEN-1:0]       i_disp_imm  [DISP_WIDTH],
    input  logic [DISP_WIDTH-1:0] i_disp_rdy,
    input  logic [$clog2(DISP_WIDTH+1)-1:0] i_disp_cnt,
    input  logic [LD_LANES-1:0]   i_wb_stall,
    input  logic [DISP_WIDTH-1:0] i_exp_rdy,
    input  logic [3:0]            i_exp_idx [DISP_WIDTH],
    input  logic [LD_LANES-1:0]   i_ld_wb_vld,
    input  ld_wb_t                i_ld_wb [LD_LANES],
    input  logic [DISP_WIDTH-1:0] i_st_vld,
    input  sq_idx_t               i_st_sq  [DISP_WIDTH],
    input  rob_idx_t              i_st_rob [DISP_WIDTH],
    input  logic                  i_exc_vld,
    input  ld_wb_t                i_exc_info,
    output int                    o_errors,
    output logic                  o_idle,
    output logic                  o_reported
);
    ld_wb_t                pend [$];
    logic [DISP_WIDTH-1:0] exp_st_vld;
    logic [3:0]            exp_st_sq  [DISP_WIDTH];
    rob_idx_t              exp_st_rob [DISP_WIDTH];
    int                    exp_cnt;
    logic [LD_LANES-1:0]   stall_q;
    int                    cur_tid;
    int                    test_err;
    int                    n_tests;
    int                    n_failed;
    int                    n_checks;

    initial begin
        o_errors   = 0;
        o_idle     = 1'b1;
        o_reported = 1'b0;
        exp_st_vld = '0;
        exp_cnt    = 0;
        stall_q    = '0;
        cur_tid    = 0;
        test_err   = 0;
        n_tests    = 0;
        n_failed   = 0;
        n_checks   = 0;
    end

    // byte access never faults, half needs bit 0 clear, word needs bits 1:0 clear
    function automatic logic misaligned(logic [2:0] op, logic [31:0] addr);
        case (op[1:0])
            2'd0:    return 1'b0;
            2'd1:    return addr[0];
            default: return addr[1:0] != 2'd0;
        endcase
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            test_err++;
            o_errors++;
        end
    endtask

    task automatic finish_test();
        if (cur_tid != 0) begin
            n_tests++;
            if (test_err != 0) begin
                n_failed++;
                $display("test %0d: %0d mismatches", cur_tid, test_err);
            end else begin
                $display("test %0d: ok", cur_tid);
            end
        end
        test_err = 0;
    endtask

    always @(posedge clk) begin : watch
        ld_wb_t      e;
        logic        exc_exp;
        ld_wb_t      exc_e;
        logic        acc;
        logic        held;
        logic [31:0] addr;
        if (!i_rst_n) begin
            pend.delete();
            exp_st_vld = '0;
            exp_cnt    = 0;
            stall_q    = '0;
        end else begin
            if (i_tid != cur_tid) begin
                finish_test();
                cur_tid = i_tid;
            end
            // a stalled lane holds itself and every younger lane
            held = 1'b0;
            for (int l = 0; l < LD_LANES; l++) begin
                held = held || stall_q[l];
                if (held && i_ld_wb_vld[l]) begin
                    $display("at %0t ns, lane %0d wrote back while held by a stall",
                             $time, l);
                    test_err++;
                    o_errors++;
                end
            end
            // writebacks leave in program order with lane 0 first
            exc_exp = 1'b0;
            exc_e   = '0;
            for (int l = 0; l < LD_LANES; l++) begin
                if (i_ld_wb_vld[l] && pend.size() == 0) begin
                    $display("at %0t ns, lane %0d wrote back with no load pending",
                             $time, l);
                    test_err++;
                    o_errors++;
                end else if (i_ld_wb_vld[l]) begin
                    e = pend.pop_front();
                    check_val($sformatf("o_ld_wb[%0d].rob", l), i_ld_wb[l].rob, e.rob);
                    check_val($sformatf("o_ld_wb[%0d].lq_idx", l), i_ld_wb[l].lq_idx,
                              e.lq_idx);
                    check_val($sformatf("o_ld_wb[%0d].addr", l), i_ld_wb[l].addr, e.addr);
                    check_val($sformatf("o_ld_wb[%0d].misalign", l),
                              i_ld_wb[l].misalign, e.misalign);
                    if (e.misalign && (!exc_exp || e.rob < exc_e.rob)) begin
                        exc_exp = 1'b1;
                        exc_e   = e;
                    end
                end
            end
            check_val("o_except_vld", i_exc_vld, exc_exp);
            if (exc_exp && i_exc_vld) begin
                check_val("o_except_info.rob", i_exc_info.rob, exc_e.rob);
                check_val("o_except_info.addr", i_exc_info.addr, exc_e.addr);
            end
            check_val("o_st_alloc_vld", i_st_vld, exp_st_vld);
            for (int i = 0; i < DISP_WIDTH; i++) begin
                if (exp_st_vld[i] && i_st_vld[i]) begin
                    check_val($sformatf("o_st_alloc_sq[%0d]", i), i_st_sq[i], exp_st_sq[i]);
                    check_val($sformatf("o_st_alloc_rob[%0d]", i), i_st_rob[i],
                              exp_st_rob[i]);
                end
            end
            check_val("o_disp_rdy", i_disp_rdy, i_exp_rdy);
            // count of ops accepted in the previous cycle
            check_val("o_disp_cnt", i_disp_cnt, exp_cnt);
            exp_cnt = $countones(i_disp_req & i_exp_rdy);
            stall_q = i_wb_stall;
            if (i_squash) begin
                pend.delete();
            end
            for (int i = 0; i < DISP_WIDTH; i++) begin
                acc           = i_disp_req[i] && i_exp_rdy[i];
                exp_st_vld[i] = acc && i_disp_op[i][2];
                exp_st_sq[i]  = i_exp_idx[i];
                exp_st_rob[i] = i_disp_rob[i];
                if (acc && !i_disp_op[i][2] && !i_squash) begin
                    addr       = i_disp_base[i] + i_disp_imm[i];
                    e.rob      = i_disp_rob[i];
                    e.lq_idx   = i_exp_idx[i];
                    e.addr     = addr;
                    e.misalign = misaligned(i_disp_op[i], addr);
                    pend.push_back(e);
                end
            end
        end
        o_idle = (pend.size() == 0);
        if (i_done && !o_reported) begin
            finish_test();
            cur_tid = 0;
            $display("tests run %0d, tests failed %0d, checks %0d, mismatches %0d",
                     n_tests, n_failed, n_checks, o_errors);
            o_reported = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_mem_block.sv */
// memory dispatch block testbench
// reads dispatch groups from a file, drives them on the falling edge
`timescale 1ns/1ns
`default_nettype none

module tb_mem_block import mem_cfg_pkg::*, mem_op_pkg::*; ();
    localparam int NF        = 27;
    localparam int MAX_LINES = 128;

    logic                  clk;
    logic                  rst_n;
    logic                  squash;
    logic [DISP_WIDTH-1:0] disp_req;
    mem_op_e               disp_op   [DISP_WIDTH];
    rob_idx_t              disp_rob  [DISP_WIDTH];
    logic [XLEN-1:0]       disp_base [DISP_WIDTH];
    logic [XLEN-1:0]       disp_imm  [DISP_WIDTH];
    logic [DISP_WIDTH-1:0] disp_rdy;
    logic [2:0]            disp_cnt;
    logic [LD_LANES-1:0]   wb_stall;
    logic [1:0]            ld_commit;
    logic [1:0]            st_commit;
    logic [LD_LANES-1:0]   wb_vld;
    ld_wb_t                wb [LD_LANES];
    logic [DISP_WIDTH-1:0] st_vld;
    sq_idx_t               st_sq  [DISP_WIDTH];
    rob_idx_t              st_rob [DISP_WIDTH];
    logic                  exc_vld;
    ld_wb_t                exc_info;

    // expected values and bookkeeping for the checker
    logic [DISP_WIDTH-1:0] exp_rdy;
    logic [3:0]            exp_idx [DISP_WIDTH];
    int                    tid;
    logic                  done;
    int                    errors;
    logic                  idle;
    logic                  reported;

    logic [31:0] fld [MAX_LINES][NF];
    int          n_lines;
    logic        file_ok;
    int          cycles;
    int          cycle_limit;
    logic        limit_set;

    mem_block i_mem_block (
        .clk(clk), .i_rst_n(rst_n), .i_squash(squash),
        .i_disp_req(disp_req), .i_disp_op(disp_op), .i_disp_rob(disp_rob),
        .i_disp_base(disp_base), .i_disp_imm(disp_imm),
        .o_disp_rdy(disp_rdy), .o_disp_cnt(disp_cnt), .i_wb_stall(wb_stall),
        .i_ld_commit_num(ld_commit), .i_st_commit_num(st_commit),
        .o_ld_wb_vld(wb_vld), .o_ld_wb(wb),
        .o_st_alloc_vld(st_vld), .o_st_alloc_sq(st_sq), .o_st_alloc_rob(st_rob),
        .o_except_vld(exc_vld), .o_except_info(exc_info)
    );

    mem_block_checker u_checker (
        .clk(clk), .i_rst_n(rst_n), .i_squash(squash), .i_done(done), .i_tid(tid),
        .i_disp_req(disp_req), .i_disp_op(disp_op), .i_disp_rob(disp_rob),
        .i_disp_base(disp_base), .i_disp_imm(disp_imm), .i_disp_rdy(disp_rdy),
        .i_disp_cnt(disp_cnt), .i_wb_stall(wb_stall),
        .i_exp_rdy(exp_rdy), .i_exp_idx(exp_idx),
        .i_ld_wb_vld(wb_vld), .i_ld_wb(wb),
        .i_st_vld(st_vld), .i_st_sq(st_sq), .i_st_rob(st_rob),
        .i_exc_vld(exc_vld), .i_exc_info(exc_info),
        .o_errors(errors), .o_idle(idle), .o_reported(reported)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int hex_val(byte c);
        if (c >= "0" && c <= "9") return c - "0";
        if (c >= "a" && c <= "f") return c - "a" + 10;
        if (c >= "A" && c <= "F") return c - "A" + 10;
        return -1;
    endfunction

    // one group per line as blank-separated hex fields
    task automatic read_tests();
        int          fd;
        string       line;
        int          k;
        int          d;
        logic [31:0] val;
        logic        in_tok;
        byte         c;
        n_lines = 0;
        file_ok = 1'b1;
        fd = $fopen("sim/mem_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file sim/mem_tests.txt");
            file_ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") continue;
            k      = 0;
            val    = '0;
            in_tok = 1'b0;
            for (int i = 0; i <= line.len(); i++) begin
                c = (i < line.len()) ? line[i] : " ";
                d = hex_val(c);
                if (d >= 0) begin
                    val    = (val << 4) | d;
                    in_tok = 1'b1;
                end else if (in_tok) begin
                    if (k < NF && n_lines < MAX_LINES) fld[n_lines][k] = val;
                    k++;
                    val    = '0;
                    in_tok = 1'b0;
                end
            end
            if (k == NF && n_lines < MAX_LINES) begin
                n_lines++;
            end else if (k != 0) begin
                $display("test file line %0d has %0d fields instead of %0d",
                         n_lines + 1, k, NF);
                file_ok = 1'b0;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_line(int n);
        tid      = fld[n][0];
        disp_req = fld[n][1][DISP_WIDTH-1:0];
        for (int i = 0; i < DISP_WIDTH; i++) begin
            disp_op[i]   = mem_op_e'(fld[n][2 + i][2:0]);
            disp_rob[i]  = rob_idx_t'(fld[n][6 + i]);
            disp_base[i] = fld[n][10 + i];
            disp_imm[i]  = fld[n][14 + i];
            exp_idx[i]   = fld[n][23 + i][3:0];
        end
        wb_stall  = fld[n][18][LD_LANES-1:0];
        ld_commit = fld[n][19][1:0];
        st_commit = fld[n][20][1:0];
        squash    = fld[n][21][0];
        exp_rdy   = fld[n][22][DISP_WIDTH-1:0];
    endtask

    task automatic drive_idle();
        disp_req  = '0;
        wb_stall  = '0;
        ld_commit = '0;
        st_commit = '0;
        squash    = 1'b0;
        exp_rdy   = '0;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            disp_op[i]   = LB;
            disp_rob[i]  = '0;
            disp_base[i] = '0;
            disp_imm[i]  = '0;
            exp_idx[i]   = '0;
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        tid       = 0;
        done      = 1'b0;
        limit_set = 1'b0;
        drive_idle();
        read_tests();
        if (!file_ok || n_lines == 0) begin
            $display("no usable stimulus, run stopped");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            cycle_limit = n_lines * 8 + 50;
            limit_set   = 1'b1;
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int n = 0; n < n_lines; n++) begin
                apply_line(n);
                @(negedge clk);
            end
            drive_idle();
            // drain until every accepted load has written back
            while (!idle) @(negedge clk);
            done = 1'b1;
            while (!reported) @(negedge clk);
            if (errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        cycles = 0;
        wait (limit_set);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, loads still pending", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/mem_tests.txt */
# tid req op0-3 rob0-3 base0-3 imm0-3 stall ldc stc squash exp_rdy idx0-3, all hex
# op 0 LB 1 LH 2 LW 4 SB 5 SH 6 SW; idx is the lq index for loads, sq index for stores
1 f 2 2 1 6 1 2 3 4 100 200 300 400 4 8 2 0 0 0 0 0 3 0 1 0 0
1 3 1 6 0 0 3 4 0 0 300 400 0 0 2 0 0 0 0 0 0 0 3 2 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 f 2 6 2 6 5 6 7 8 40 80 44 84 0 0 4 0 0 0 0 0 f 3 1 4 2
2 f 2 6 2 6 9 a b c 48 88 4c 8c 0 4 8 c 0 0 0 0 f 5 3 6 4
2 f 1 5 1 5 d e f 10 50 90 54 94 2 2 2 2 0 0 0 0 f 7 5 8 6
2 f 0 4 0 4 11 12 13 14 60 a0 61 a1 0 0 0 0 0 0 0 0 f 9 7 a 8
2 f 2 6 2 6 15 16 17 18 70 b0 74 b4 0 0 0 0 0 0 0 0 f b 9 c a
2 f 2 6 2 6 19 1a 1b 1c 80 c0 84 c4 0 0 0 0 0 2 0 0 0 0 0 0 0
2 f 2 6 2 6 19 1a 1b 1c 80 c0 84 c4 0 0 0 0 0 2 2 0 f d b e c
2 f 2 6 2 6 1d 1e 1f 20 90 d0 94 d4 0 0 0 0 0 2 2 0 f f d 0 e
2 f 2 6 2 6 21 22 23 24 a0 e0 a4 e4 0 0 0 0 0 2 2 0 f 1 f 2 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 3 0 1 0 0 25 26 0 0 101 101 0 0 0 0 0 0 0 2 0 0 3 3 4 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 3 2 1 0 0 27 28 0 0 100 200 0 0 2 1 0 0 0 2 0 0 3 5 6 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 3 2 2 0 0 29 2a 0 0 300 304 0 0 0 0 0 0 1 2 0 0 3 7 8 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 3 1 2 0 0 2b 2c 0 0 1 400 0 0 0 0 0 0 0 2 0 0 3 9 a 0 0
5 3 2 2 0 0 2d 2e 0 0 500 504 0 0 0 0 0 0 0 2 0 0 3 b c 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 0 0 1 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

/* verilog.f */
hdl/mem_cfg_pkg.sv
hdl/mem_op_pkg.sv
hdl/mem_disp_if.sv
hdl/mem_dispatch_ctrl.sv
hdl/lsq_alloc.sv
hdl/load_issue_buffer.sv
hdl/load_pipe.sv
hdl/mem_block.sv
sim/mem_block_checker.sv
sim/tb_mem_block.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the memory dispatch block testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_mem_block \
    -o sim_tb_mem_block > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb_mem_block > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0
